// ==== src/fpu_pkg.sv ====
// fpu package with operation codes, rounding codes, issued request and float constants
package fpu_pkg;

  ////////////////////////////////////////
  // single-precision field layout
  ////////////////////////////////////////
  localparam int exp_w    = 8;   // exponent bits
  localparam int man_w    = 23;  // stored mantissa bits
  localparam int exp_bias = 127;

  localparam logic [31:0] canon_nan = 32'h7fc0_0000;  // riscv canonical qnan

  // converter normalize bound, one shift per cycle
  localparam int cvt_max_iter = 32;
  localparam int cnt_w        = $clog2(cvt_max_iter);

  ////////////////////////////////////////
  // operation select
  ////////////////////////////////////////
  typedef enum logic [4:0] {
    op_fsgnj     = 5'd5,
    op_fsgnjn    = 5'd6,
    op_fsgnjx    = 5'd7,
    op_fmax      = 5'd8,
    op_fmin      = 5'd9,
    op_feq       = 5'd10,
    op_flt       = 5'd11,
    op_fle       = 5'd12,
    op_fmv       = 5'd13,
    op_fclass    = 5'd14,
    op_fcvt_s_w  = 5'd20,  // signed int to float
    op_fcvt_s_wu = 5'd21   // unsigned int to float
  } fpu_op_e;

  // rounding modes, 5 and 6 reserved
  typedef enum logic [2:0] {
    rm_rne = 3'd0,  // nearest, ties to even
    rm_rtz = 3'd1,  // toward zero
    rm_rdn = 3'd2,  // toward -inf
    rm_rup = 3'd3,  // toward +inf
    rm_rmm = 3'd4,  // nearest, ties away
    rm_dyn = 3'd7   // take frm
  } rnd_mode_e;

  // one issued operation, decoded once at issue
  typedef struct packed {
    fpu_op_e     op;
    rnd_mode_e   rm;          // already resolved, never dyn
    logic [31:0] a;
    logic [31:0] b;
    logic        is_cvt;      // fcvt.s.w or fcvt.s.wu
    logic        cvt_signed;  // fcvt.s.w only
  } fpu_req_t;

endpackage

// ==== src/fpu_issue.sv ====
// fpu issue stage, resolves the rounding mode, decodes the select and registers one request
`timescale 1ns/10ps

module fpu_issue import fpu_pkg::*; (
  input  logic        g_clk,
  input  logic        arst_n,
  input  logic        fp_enable,
  input  logic        stall,
  input  fpu_op_e     fpusel,
  input  rnd_mode_e   frm,
  input  rnd_mode_e   sys_rm,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output fpu_req_t    req,
  output logic        issued
);

  logic      issue;   // accepted this edge
  rnd_mode_e rm_sel;  // before reserved check
  rnd_mode_e rm_res;
  fpu_req_t  req_d;

  // strobe dropped while a conversion holds the unit
  assign issue = fp_enable & ~stall;

  ////////////////////////////////////////
  // rounding mode resolve
  ////////////////////////////////////////
  always_comb begin
    rm_sel = (sys_rm == rm_dyn) ? frm : sys_rm;  // dyn defers to frm
    case (rm_sel)
      rm_rne, rm_rtz, rm_rdn, rm_rup, rm_rmm: rm_res = rm_sel;
      default: rm_res = rm_rne;  // 5, 6 and a dyn frm
    endcase
  end

  // decode once, downstream only looks at the flags
  always_comb begin
    req_d.op         = fpusel;
    req_d.rm         = rm_res;
    req_d.a          = a;
    req_d.b          = b;
    req_d.is_cvt     = (fpusel == op_fcvt_s_w) || (fpusel == op_fcvt_s_wu);
    req_d.cvt_signed = (fpusel == op_fcvt_s_w);
  end

  ////////////////////////////////////////
  // request register
  ////////////////////////////////////////
  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      req    <= '0;
      issued <= 1'b0;
    end else begin
      issued <= issue;  // one-cycle pulse
      if (issue) begin
        req <= req_d;   // held until next issue
      end
    end
  end

endmodule

// ==== src/fpu_misc_ops.sv ====
// fpu single-cycle ops, sign injection, compares, min/max, classify and move
`timescale 1ns/10ps

module fpu_misc_ops import fpu_pkg::*; (
  input  fpu_req_t    req,
  output logic [31:0] misc_res
);

  logic               a_sign, b_sign;
  logic [exp_w-1:0]   a_exp, b_exp;
  logic [man_w-1:0]   a_man, b_man;
  logic               a_nan, b_nan;
  logic               a_zero, b_zero;
  logic               a_inf, a_sub, a_snan;
  logic               any_nan;
  logic               lt_raw;   // total order, -0 below +0
  logic               lt_ieee;  // ieee order, zeros equal
  logic               eq_ieee;
  logic [9:0]         cls;

  ////////////////////////////////////////
  // field split
  ////////////////////////////////////////
  assign a_sign = req.a[31];
  assign b_sign = req.b[31];
  assign a_exp  = req.a[30 -: exp_w];
  assign b_exp  = req.b[30 -: exp_w];
  assign a_man  = req.a[man_w-1:0];
  assign b_man  = req.b[man_w-1:0];

  assign a_nan  = (a_exp == '1) && (a_man != '0);
  assign b_nan  = (b_exp == '1) && (b_man != '0);
  assign a_zero = (req.a[30:0] == '0);
  assign b_zero = (req.b[30:0] == '0);
  assign a_inf  = (a_exp == '1) && (a_man == '0);
  assign a_sub  = (a_exp == '0) && (a_man != '0);
  assign a_snan = a_nan & ~a_man[man_w-1];  // quiet bit clear
  assign any_nan = a_nan | b_nan;

  // sign-magnitude ordering
  always_comb begin
    if (a_sign != b_sign) begin
      lt_raw = a_sign;                        // negative one is lower
    end else if (!a_sign) begin
      lt_raw = req.a[30:0] < req.b[30:0];
    end else begin
      lt_raw = req.a[30:0] > req.b[30:0];     // bigger magnitude is lower
    end
  end

  assign lt_ieee = lt_raw & ~(a_zero & b_zero);
  assign eq_ieee = (req.a == req.b) | (a_zero & b_zero);

  ////////////////////////////////////////
  // fclass, one-hot in riscv bit order
  ////////////////////////////////////////
  always_comb begin
    cls    = '0;
    cls[0] = a_sign & a_inf;
    cls[1] = a_sign & ~a_nan & ~a_inf & (a_exp != '0);  // -normal
    cls[2] = a_sign & a_sub;
    cls[3] = a_sign & a_zero;
    cls[4] = ~a_sign & a_zero;
    cls[5] = ~a_sign & a_sub;
    cls[6] = ~a_sign & ~a_nan & ~a_inf & (a_exp != '0);
    cls[7] = ~a_sign & a_inf;
    cls[8] = a_snan;
    cls[9] = a_nan & ~a_snan;
  end

  ////////////////////////////////////////
  // result select
  ////////////////////////////////////////
  always_comb begin
    case (req.op)
      op_fsgnj:  misc_res = {b_sign, req.a[30:0]};
      op_fsgnjn: misc_res = {~b_sign, req.a[30:0]};
      op_fsgnjx: misc_res = {a_sign ^ b_sign, req.a[30:0]};
      op_fmin, op_fmax: begin
        if (a_nan && b_nan) begin
          misc_res = canon_nan;
        end else if (a_nan) begin
          misc_res = req.b;  // the number wins over nan
        end else if (b_nan) begin
          misc_res = req.a;
        end else if ((req.op == op_fmin) == lt_raw) begin
          misc_res = req.a;
        end else begin
          misc_res = req.b;
        end
      end
      op_feq:    misc_res = {31'd0, ~any_nan & eq_ieee};
      op_flt:    misc_res = {31'd0, ~any_nan & lt_ieee};
      op_fle:    misc_res = {31'd0, ~any_nan & (lt_ieee | eq_ieee)};
      op_fmv:    misc_res = req.a;                  // raw bits
      op_fclass: misc_res = {22'd0, cls};
      default:   misc_res = canon_nan;              // unsupported
    endcase
  end

endmodule

// ==== src/fpu_int_to_float.sv ====
// iterative int to single converter, one normalize shift per cycle then rounding
`timescale 1ns/10ps

module fpu_int_to_float import fpu_pkg::*; (
  input  logic        g_clk,
  input  logic        arst_n,
  input  logic        start,
  input  fpu_req_t    req,
  output logic [31:0] cvt_res,
  output logic        cvt_done
);

  typedef enum logic [1:0] {s_idle, s_norm, s_round, s_done} cvt_state_e;

  cvt_state_e       state;
  logic [31:0]      mag;       // shifted magnitude
  logic             sign;
  logic [cnt_w-1:0] cnt;       // shifts so far
  rnd_mode_e        rm;
  logic [31:0]      mag_in;
  logic [23:0]      sig;
  logic             guard, sticky, round_up;
  logic [24:0]      sig_rnd;   // extra bit catches the carry
  logic [7:0]       exp_pre, exp_fin;

  // 80000000 stays 80000000 as unsigned
  assign mag_in = (req.cvt_signed && req.a[31]) ? (~req.a + 32'd1) : req.a;

  ////////////////////////////////////////
  // rounding on the normalized word
  ////////////////////////////////////////
  assign sig    = mag[31:8];
  assign guard  = mag[7];
  assign sticky = |mag[6:0];

  always_comb begin
    case (rm)
      rm_rtz:  round_up = 1'b0;
      rm_rdn:  round_up = sign & (guard | sticky);
      rm_rup:  round_up = ~sign & (guard | sticky);
      rm_rmm:  round_up = guard;                     // ties away
      default: round_up = guard & (sticky | sig[0]); // rne
    endcase
  end

  assign sig_rnd = {1'b0, sig} + {24'd0, round_up};
  assign exp_pre = 8'(exp_bias + cvt_max_iter - 1) - 8'(cnt);
  assign exp_fin = exp_pre + {7'd0, sig_rnd[24]};  // carry bumps exponent
  assign cvt_done = (state == s_done);

  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= s_idle;
    end else begin
      case (state)
        s_idle:  if (start) state <= (mag_in == '0) ? s_done : s_norm;
        s_norm:  if (mag[31] || mag[30]) state <= s_round;  // top set after this edge
        s_round: state <= s_done;
        default: state <= s_idle;
      endcase
    end
  end

  // datapath
  always_ff @(posedge g_clk) begin
    case (state)
      s_idle: if (start) begin
        mag     <= mag_in;
        sign    <= req.cvt_signed & req.a[31];
        cnt     <= '0;
        rm      <= req.rm;
        cvt_res <= '0;  // zero input is +0
      end
      s_norm: if (!mag[31]) begin
        mag <= mag << 1;
        cnt <= cnt + 1'b1;
      end
      s_round: cvt_res <= {sign, exp_fin, sig_rnd[22:0]};
      default: ;
    endcase
  end

endmodule

// ==== src/fpu_writeback.sv ====
// fpu writeback, picks and registers the result, pulses res_valid and drives stall
`timescale 1ns/10ps

module fpu_writeback (
  input  logic        g_clk,
  input  logic        arst_n,
  input  logic        issued,
  input  logic        is_cvt,
  input  logic [31:0] misc_res,
  input  logic [31:0] cvt_res,
  input  logic        cvt_done,
  output logic [31:0] res,
  output logic        res_valid,
  output logic        stall
);

  logic busy;      // conversion in flight
  logic cvt_go;    // conversion issued last edge
  logic misc_go;   // single-cycle op issued last edge

  assign cvt_go  = issued & is_cvt;
  assign misc_go = issued & ~is_cvt;

  // high from the issued cycle on, so the next strobe is dropped
  assign stall = busy | cvt_go;

  ////////////////////////////////////////
  // result register
  ////////////////////////////////////////
  always_ff @(posedge g_clk or negedge arst_n) begin
    if (!arst_n) begin
      res       <= '0;
      res_valid <= 1'b0;
      busy      <= 1'b0;
    end else begin
      res_valid <= 1'b0;  // pulse by default
      if (cvt_done) begin
        res       <= cvt_res;
        res_valid <= 1'b1;
        busy      <= 1'b0;  // stall drops with res_valid
      end else if (misc_go) begin
        res       <= misc_res;
        res_valid <= 1'b1;
      end
      if (cvt_go) begin
        busy <= 1'b1;
      end
    end
  end

endmodule

// ==== src/fpu_top.sv ====
// fpu top level, issue stage feeding the misc ops, the converter and writeback
`timescale 1ns/10ps

module fpu_top import fpu_pkg::*; (
  input  logic        g_clk,
  input  logic        arst_n,
  input  logic        fp_enable,
  input  fpu_op_e     fpusel,
  input  rnd_mode_e   frm,
  input  rnd_mode_e   sys_rm,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] res,
  output logic        res_valid,
  output logic        stall
);

  fpu_req_t    req;
  logic        issued;
  logic [31:0] misc_res, cvt_res;
  logic        cvt_done;

  fpu_issue u_issue (
    .g_clk, .arst_n, .fp_enable, .stall, .fpusel, .frm, .sys_rm, .a, .b, .req, .issued
  );

  fpu_misc_ops u_misc (.req, .misc_res);

  // converter only launches on a conversion issue
  fpu_int_to_float u_i2f (
    .g_clk, .arst_n, .start(issued & req.is_cvt), .req, .cvt_res, .cvt_done
  );

  fpu_writeback u_wb (
    .g_clk, .arst_n, .issued, .is_cvt(req.is_cvt), .misc_res, .cvt_res, .cvt_done,
    .res, .res_valid, .stall
  );

endmodule

// ==== tests/fpu_assertions.sv ====
// fpu protocol checks on stall and res_valid, bound into the top level
`timescale 1ns/10ps

module fpu_assertions (
  input logic g_clk,
  input logic arst_n,
  input logic res_valid,
  input logic stall
);

  // a conversion result is a single pulse
  conv_single_pulse: assert property (@(posedge g_clk) disable iff (!arst_n)
    res_valid && $past(stall) |=> !res_valid)
    else $error("conversion result held res_valid for two cycles");

  // result after a stalled cycle ends the conversion, stall drops with it
  valid_no_stall: assert property (@(posedge g_clk) disable iff (!arst_n)
    res_valid && $past(stall) |-> !stall)
    else $error("stall high in the res_valid cycle that ends a conversion");

  // quiet outputs while in reset
  reset_quiet: assert property (@(posedge g_clk) !arst_n |-> !stall && !res_valid)
    else $error("stall or res_valid high during reset");

  stall_ends_with_result: assert property (@(posedge g_clk) disable iff (!arst_n)
    $fell(stall) |-> res_valid)
    else $error("stall fell without a result");

endmodule

bind fpu_top fpu_assertions u_fpu_assertions (.g_clk, .arst_n, .res_valid, .stall);

// ==== tests/fpu_tb.sv ====
// fpu testbench, lfsr driven operations checked against a reference model
`timescale 1ns/10ps

module fpu_tb import fpu_pkg::*; ();

  localparam int num_ops         = 400;
  localparam int reset_cycles    = 16;
  localparam int watchdog_cycles = (num_ops + 1) * (cvt_max_iter + 4) + reset_cycles;

  typedef struct packed {
    logic [31:0] value;      // expected res
    logic        is_cvt;
    logic [31:0] issue_cyc;  // cycle count at the accepting edge
  } expect_t;

  logic        g_clk, arst_n, fp_enable, res_valid, stall;
  fpu_op_e     fpusel;
  rnd_mode_e   frm, sys_rm;
  logic [31:0] a, b, res;
  logic [31:0] lfsr = 32'hd951f076;
  logic [31:0] cyc = '0;
  logic        cvt_busy = 1'b0;  // model view, conversion accepted and no result yet
  expect_t     cur_exp;   // op now on the inputs
  expect_t     exp_q[$];  // one per accepted op
  int          value_errors = 0, proto_errors = 0, dropped = 0, cvt_ops = 0;

  fpu_top uut (.*);

  ////////////////////////////////////////
  // random source
  ////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // misc ops, conversions, then any code
  function automatic logic [4:0] pick_code();
    logic [3:0] idx;
    idx = 4'(rand_bits(4));
    if (idx < 10) return 5'(idx + 5);
    if (idx < 14) return 5'(20 + idx[0]);
    return 5'(rand_bits(5));  // mostly unsupported
  endfunction

  function automatic logic [31:0] pick_operand();
    logic [31:0] v, r;
    logic [2:0]  kind;
    logic        sgn;
    if (rand_bits(2) != 0) return rand_bits(32);
    kind = 3'(rand_bits(3));
    sgn  = rand_bits(1);
    r    = rand_bits(23);
    case (kind)
      3'd0:    v = 32'h0000_0000;              // zero, int min when negative
      3'd1:    v = 32'h7f80_0000;              // inf
      3'd2:    v = {9'h0ff, 1'b1, r[21:0]};    // quiet nan
      3'd3:    v = {9'h0ff, 1'b0, r[21:1], 1'b1};
      3'd4:    v = {9'h000, r[22:0]};          // subnormal
      3'd5:    v = {8'h01, 22'd0, r[1:0]};     // rounding ties
      3'd6:    v = 32'h7fff_ffff;
      default: v = 32'h0000_0001;              // longest normalize
    endcase
    return {sgn, v[30:0]};
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic logic [2:0] resolve_rm(input logic [2:0] f, input logic [2:0] s);
    logic [2:0] r;
    r = (s == rm_dyn) ? f : s;
    return (r > 3'd4) ? 3'd0 : r;  // reserved codes round to nearest even
  endfunction

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 0);
  endfunction

  // signed integer key, -0 below +0 only when zero_below
  function automatic longint order_key(input logic [31:0] x, input logic zero_below);
    longint mag;
    mag = longint'(x[30:0]);
    if (!x[31]) return mag;
    return zero_below ? -mag - 1 : -mag;
  endfunction

  function automatic logic [31:0] class_mask(input logic [31:0] x);
    int idx;
    if (is_nan(x)) idx = x[22] ? 9 : 8;
    else if (x[30:23] == 8'hff) idx = x[31] ? 0 : 7;
    else if (x[30:0] == 0) idx = x[31] ? 3 : 4;
    else if (x[30:23] == 0) idx = x[31] ? 2 : 5;
    else idx = x[31] ? 1 : 6;
    return 32'd1 << idx;
  endfunction

  function automatic logic [31:0] convert_ref(input logic [31:0] x, input logic sgnd,
                                              input logic [2:0] rm);
    longint mag, sig, rem, half;
    int     p, sh, e, i;
    logic   neg, up;
    neg = sgnd && x[31];
    mag = neg ? (64'h1_0000_0000 - longint'(x)) : longint'(x);
    if (mag == 0) return 32'h0;
    p = 0;
    for (i = 0; i < 32; i++) if (mag[i]) p = i;  // leading one
    e = exp_bias + p;
    if (p <= 23) return {neg, 8'(e), 23'(mag << (23 - p))};  // exact
    sh   = p - 23;
    sig  = mag >> sh;
    rem  = mag - (sig << sh);
    half = 64'd1 << (sh - 1);
    case (rm)
      3'd1:    up = 1'b0;
      3'd2:    up = neg && (rem != 0);
      3'd3:    up = !neg && (rem != 0);
      3'd4:    up = (rem >= half);
      default: up = (rem > half) || ((rem == half) && sig[0]);
    endcase
    sig = sig + up;
    if (sig == (64'd1 << 24)) begin
      sig = sig >> 1;  // carry out of the significand
      e++;
    end
    return {neg, 8'(e), 23'(sig)};
  endfunction

  function automatic logic [31:0] model_result(input logic [4:0] code, input logic [2:0] rm,
                                               input logic [31:0] x, input logic [31:0] y);
    logic   any_nan;
    longint kx, ky;
    any_nan = is_nan(x) || is_nan(y);
    kx      = order_key(x, 1'b0);
    ky      = order_key(y, 1'b0);
    case (code)
      op_fsgnj:  return {y[31], x[30:0]};
      op_fsgnjn: return {~y[31], x[30:0]};
      op_fsgnjx: return {x[31] ^ y[31], x[30:0]};
      op_feq:    return {31'd0, !any_nan && (kx == ky)};
      op_flt:    return {31'd0, !any_nan && (kx < ky)};
      op_fle:    return {31'd0, !any_nan && (kx <= ky)};
      op_fmin, op_fmax: begin
        if (is_nan(x) && is_nan(y)) return canon_nan;
        if (is_nan(x)) return y;
        if (is_nan(y)) return x;
        if ((order_key(x, 1'b1) < order_key(y, 1'b1)) == (code == op_fmin)) return x;
        return y;
      end
      op_fmv:       return x;
      op_fclass:    return class_mask(x);
      op_fcvt_s_w:  return convert_ref(x, 1'b1, rm);
      op_fcvt_s_wu: return convert_ref(x, 1'b0, rm);
      default:      return canon_nan;
    endcase
  endfunction

  ////////////////////////////////////////
  // clock, cycle count, watchdog
  ////////////////////////////////////////
  initial begin
    g_clk = 1'b0;
    forever #20 g_clk = ~g_clk;  // 40 ns
  end

  always @(posedge g_clk) cyc <= cyc + 1;

  initial begin
    repeat (watchdog_cycles) @(posedge g_clk);
    $display("watchdog expired after %0d cycles, value errors %0d, protocol errors %0d",
             watchdog_cycles, value_errors, proto_errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // result check and expected queue, all on the falling edge
  always @(negedge g_clk) begin
    expect_t e;
    int      lat;
    if (arst_n && res_valid) begin
      if (exp_q.size() == 0) begin
        $display("res_valid pulse at %0t with no operation outstanding", $time);
        proto_errors++;
      end else begin
        e   = exp_q.pop_front();
        lat = int'(cyc - e.issue_cyc);
        if (e.is_cvt) cvt_busy = 1'b0;  // conversion result ends the stall
        assert (res === e.value) else begin
          $display("FAIL %0t res expected %h actual %h", $time, e.value, res);
          value_errors++;
        end
        assert (e.is_cvt ? (lat >= 3 && lat <= cvt_max_iter + 3) : (lat == 2)) else begin
          $display("result at %0t came %0d cycles after issue", $time, lat);
          proto_errors++;
        end
      end
    end
    if (arst_n) begin
      assert (stall === cvt_busy) else begin
        $display("FAIL %0t stall expected %b actual %b", $time, cvt_busy, stall);
        value_errors++;
      end
    end
    if (arst_n && fp_enable && !cvt_busy) begin
      e           = cur_exp;  // accepted on the coming edge
      e.issue_cyc = cyc;
      exp_q.push_back(e);
      if (e.is_cvt) cvt_busy = 1'b1;  // stall expected from the issued cycle
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  initial begin
    logic [4:0]  op_code;
    logic [2:0]  f_rm, s_rm;
    logic [31:0] opa, opb;
    int          op_idx, wait_cnt;
    fp_enable = 1'b0;
    fpusel    = op_fmv;
    frm       = rm_rne;
    sys_rm    = rm_rne;
    a         = '0;
    b         = '0;
    arst_n    = 1'b1;
    #5 arst_n = 1'b0;
    repeat (reset_cycles) @(posedge g_clk);
    arst_n <= 1'b1;
    for (op_idx = 0; op_idx < num_ops; op_idx++) begin
      op_code = pick_code();
      opa     = pick_operand();
      opb     = pick_operand();
      f_rm    = 3'(rand_bits(3));
      s_rm    = rand_bits(1) ? 3'd7 : 3'(rand_bits(3));  // dyn half the time
      @(posedge g_clk);
      fp_enable <= 1'b1;
      fpusel    <= fpu_op_e'(op_code);
      frm       <= rnd_mode_e'(f_rm);
      sys_rm    <= rnd_mode_e'(s_rm);
      a         <= opa;
      b         <= opb;
      cur_exp.value  = model_result(op_code, resolve_rm(f_rm, s_rm), opa, opb);
      cur_exp.is_cvt = op_code inside {op_fcvt_s_w, op_fcvt_s_wu};
      @(negedge g_clk);
      while (stall) begin
        dropped++;  // strobe ignored, held for the next edge
        @(negedge g_clk);
      end
      if (cur_exp.is_cvt) cvt_ops++;
      if (rand_bits(2) == 0) begin
        @(posedge g_clk);
        fp_enable <= 1'b0;  // idle gap
      end
    end
    @(posedge g_clk);
    fp_enable <= 1'b0;
    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < cvt_max_iter + 4) begin
      @(posedge g_clk);
      wait_cnt++;
    end
    repeat (4) @(posedge g_clk);  // room for stray pulses
    assert (exp_q.size() == 0) else begin
      $display("%0d results never arrived", exp_q.size());
      proto_errors += exp_q.size();
    end
    $display("ops %0d, conversions %0d, dropped strobes %0d, value errors %0d, protocol errors %0d",
             num_ops, cvt_ops, dropped, value_errors, proto_errors);
    if (value_errors + proto_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== flist.f ====
src/fpu_pkg.sv
src/fpu_issue.sv
src/fpu_misc_ops.sv
src/fpu_int_to_float.sv
src/fpu_writeback.sv
src/fpu_top.sv
tests/fpu_assertions.sv
tests/fpu_tb.sv

// ==== Bender.yml ====
package:
  name: fpu

sources:
  - src/fpu_pkg.sv
  - src/fpu_issue.sv
  - src/fpu_misc_ops.sv
  - src/fpu_int_to_float.sv
  - src/fpu_writeback.sv
  - src/fpu_top.sv
  - target: test
    files:
      - tests/fpu_assertions.sv
      - tests/fpu_tb.sv
